//--- Bender.yml
package:
  name: ex_stage

sources:
  - files:
      - hw/ex_pkg.sv
      - hw/ex_alu.sv
      - hw/ex_branch.sv
      - hw/ex_mem_req.sv
      - hw/ex_div_ctrl.sv
      - hw/ex_div_count.sv
      - hw/ex_div_datapath.sv
      - hw/ex_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/ex_tb.sv

//--- hw/ex_alu.sv
// integer alu: add, sub, logic, compare and shifts for I and R type
`timescale 1ns/1ns
module ex_alu (
    input  logic [31:0]             inst_i,
    input  logic [ex_pkg::xlen-1:0] op1_i,
    input  logic [ex_pkg::xlen-1:0] op2_i,
    output logic [ex_pkg::xlen-1:0] result_o,
    output logic                    wen_o
);
    import ex_pkg::*;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [4:0]      shamt;
    logic [xlen-1:0] sum;
    logic [xlen-1:0] diff;
    logic            lt_s;
    logic            lt_u;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];
    assign shamt  = op2_i[4:0];

    // shared adder also serves lui, auipc and the link address
    assign sum  = op1_i + op2_i;
    assign diff = op1_i - op2_i;
    assign lt_s = $signed(op1_i) < $signed(op2_i);
    assign lt_u = op1_i < op2_i;

    always_comb begin
        result_o = '0;
        wen_o    = 1'b0;
        case (opcode)
            op_imm, op_reg: begin
                // muldiv encodings leave the alu alone
                wen_o = (opcode == op_imm) || (funct7 == f7_base) || (funct7 == f7_alt);
                case (funct3)
                    f3_add_sub: begin
                        if (opcode == op_reg && funct7 == f7_alt) begin
                            result_o = diff;
                        end else begin
                            result_o = sum;
                        end
                    end
                    f3_sll:  result_o = op1_i << shamt;
                    f3_slt:  result_o = {{(xlen-1){1'b0}}, lt_s};
                    f3_sltu: result_o = {{(xlen-1){1'b0}}, lt_u};
                    f3_xor:  result_o = op1_i ^ op2_i;
                    f3_srl_sra: begin
                        if (funct7 == f7_alt) begin
                            result_o = $signed(op1_i) >>> shamt;
                        end else begin
                            result_o = op1_i >> shamt;
                        end
                    end
                    f3_or:   result_o = op1_i | op2_i;
                    f3_and:  result_o = op1_i & op2_i;
                    default: result_o = '0;
                endcase
            end
            op_lui, op_auipc, op_jal, op_jalr: begin
                result_o = sum;   // operands prepared by decode
                wen_o    = 1'b1;
            end
            default: begin
                result_o = '0;
                wen_o    = 1'b0;
            end
        endcase
    end

endmodule

//--- hw/ex_branch.sv
// jump and branch decision with the finished target address
`timescale 1ns/1ns
module ex_branch (
    input  logic [31:0]             inst_i,
    input  logic [ex_pkg::xlen-1:0] pc_i,
    input  logic [ex_pkg::xlen-1:0] rs1_data_i,
    input  logic [ex_pkg::xlen-1:0] op1_i,
    input  logic [ex_pkg::xlen-1:0] op2_i,
    output logic                    jump_en_o,
    output logic [ex_pkg::xlen-1:0] jump_addr_o
);
    import ex_pkg::*;

    logic [xlen-1:0] j_imm;
    logic [xlen-1:0] i_imm;
    logic [xlen-1:0] b_imm;
    logic [xlen-1:0] jalr_sum;
    logic            taken;

    assign j_imm = {{(xlen-20){inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
    assign i_imm = {{(xlen-12){inst_i[31]}}, inst_i[31:20]};
    assign b_imm = {{(xlen-12){inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign jalr_sum = rs1_data_i + i_imm;

    // branch condition on the prepared operands
    always_comb begin
        case (inst_i[14:12])
            f3_beq:  taken = op1_i == op2_i;
            f3_bne:  taken = op1_i != op2_i;
            f3_blt:  taken = $signed(op1_i) < $signed(op2_i);
            f3_bge:  taken = $signed(op1_i) >= $signed(op2_i);
            f3_bltu: taken = op1_i < op2_i;
            f3_bgeu: taken = op1_i >= op2_i;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        jump_en_o   = 1'b0;
        jump_addr_o = reset_pc;
        case (inst_i[6:0])
            op_jal: begin
                jump_en_o   = 1'b1;
                jump_addr_o = pc_i + j_imm;
            end
            op_jalr: begin
                jump_en_o   = 1'b1;
                jump_addr_o = {jalr_sum[xlen-1:1], 1'b0};   // lsb cleared
            end
            op_branch: begin
                jump_en_o = taken;
                if (taken) begin
                    jump_addr_o = pc_i + b_imm;
                end
            end
            default: ;
        endcase
    end

endmodule

//--- hw/ex_div_count.sv
// iteration down counter for the divider
`timescale 1ns/1ns
module ex_div_count (
    input  logic clk,
    input  logic rstn,
    input  logic load_i,
    input  logic step_i,
    output logic last_o
);
    import ex_pkg::*;

    logic [count_w-1:0] cnt_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cnt_q <= '0;
        end else if (load_i) begin
            cnt_q <= count_w'(div_iters - 1);
        end else if (step_i && cnt_q != '0) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    assign last_o = step_i && cnt_q == '0;   // final step

endmodule

//--- hw/ex_div_ctrl.sv
// divide sequencer FSM: idle, busy, done, with the upstream hold
`timescale 1ns/1ns
module ex_div_ctrl (
    input  logic clk,
    input  logic rstn,
    input  logic start_i,
    input  logic last_i,
    output logic busy_o,
    output logic step_o,
    output logic done_o,
    output logic hold_o
);
    import ex_pkg::*;

    div_state_t state_q;
    div_state_t state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            div_idle: begin
                if (start_i) begin
                    state_d = div_busy;
                end
            end
            div_busy: begin
                if (last_i) begin
                    state_d = div_done;
                end
            end
            div_done: state_d = div_idle;   // result out for one cycle
            default:  state_d = div_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state_q <= div_idle;
        end else begin
            state_q <= state_d;
        end
    end

    assign busy_o = state_q != div_idle;
    assign step_o = state_q == div_busy;
    assign done_o = state_q == div_done;
    // stall from the issue cycle on, released in done
    assign hold_o = (state_q == div_idle && start_i) || state_q == div_busy;

    // ------------------------------------------------------------
    a_start_idle: assert property (@(posedge clk) disable iff (!rstn)
        start_i |-> state_q == div_idle);
    a_done_once: assert property (@(posedge clk) disable iff (!rstn)
        state_q == div_done |=> state_q == div_idle);

endmodule

//--- hw/ex_div_datapath.sv
// shift-subtract divider with sign handling and divide by zero rules
`timescale 1ns/1ns
module ex_div_datapath (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          start_i,
    input  logic                          step_i,
    input  logic [2:0]                    funct3_i,
    input  logic [ex_pkg::xlen-1:0]       dividend_i,
    input  logic [ex_pkg::xlen-1:0]       divisor_i,
    input  logic [ex_pkg::reg_addr_w-1:0] rd_addr_i,
    output logic [ex_pkg::xlen-1:0]       result_o,
    output logic [ex_pkg::reg_addr_w-1:0] rd_addr_o
);
    import ex_pkg::*;

    logic                  is_signed;
    logic                  a_neg;
    logic                  b_neg;
    logic [xlen-1:0]       a_abs;
    logic [xlen-1:0]       b_abs;
    logic [xlen-1:0]       rem_q;
    logic [xlen-1:0]       quo_q;    // dividend shifts out, quotient in
    logic [xlen-1:0]       dvs_q;
    logic [reg_addr_w-1:0] rd_q;
    logic                  neg_quo_q;
    logic                  neg_rem_q;
    logic                  is_rem_q;
    logic [xlen:0]         trial;

    assign is_signed = funct3_i == f3_div || funct3_i == f3_rem;
    assign a_neg     = is_signed && dividend_i[xlen-1];
    assign b_neg     = is_signed && divisor_i[xlen-1];
    assign a_abs     = a_neg ? -dividend_i : dividend_i;
    assign b_abs     = b_neg ? -divisor_i : divisor_i;

    // ------------------------------------------------------------
    // sign and operation flags
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            neg_quo_q <= 1'b0;
            neg_rem_q <= 1'b0;
            is_rem_q  <= 1'b0;
        end else if (start_i) begin
            // x/0 keeps the all ones quotient positive
            neg_quo_q <= (a_neg ^ b_neg) && divisor_i != '0;
            neg_rem_q <= a_neg;   // remainder follows the dividend
            is_rem_q  <= funct3_i == f3_rem || funct3_i == f3_remu;
        end
    end

    // ------------------------------------------------------------
    // one quotient bit per step
    assign trial = {rem_q, quo_q[xlen-1]} - {1'b0, dvs_q};

    always_ff @(posedge clk) begin
        if (start_i) begin
            rem_q <= '0;
            quo_q <= a_abs;
            dvs_q <= b_abs;
            rd_q  <= rd_addr_i;
        end else if (step_i) begin
            if (!trial[xlen]) begin
                rem_q <= trial[xlen-1:0];
                quo_q <= {quo_q[xlen-2:0], 1'b1};
            end else begin
                rem_q <= {rem_q[xlen-2:0], quo_q[xlen-1]};
                quo_q <= {quo_q[xlen-2:0], 1'b0};
            end
        end
    end

    // min / -1 lands on min with remainder zero without a special case
    always_comb begin
        if (is_rem_q) begin
            result_o = neg_rem_q ? -rem_q : rem_q;
        end else begin
            result_o = neg_quo_q ? -quo_q : quo_q;
        end
    end

    assign rd_addr_o = rd_q;

endmodule

//--- hw/ex_mem_req.sv
// load and store request with byte lane steering
`timescale 1ns/1ns
module ex_mem_req (
    input  logic [31:0]                   inst_i,
    input  logic [ex_pkg::xlen-1:0]       op1_i,
    input  logic [ex_pkg::xlen-1:0]       op2_i,
    input  logic [ex_pkg::xlen-1:0]       rs2_data_i,
    output logic                          cs_o,
    output logic                          we_o,
    output logic [ex_pkg::byte_lanes-1:0] be_o,
    output logic [ex_pkg::xlen-1:0]       addr_o,
    output logic [ex_pkg::xlen-1:0]       wdata_o
);
    import ex_pkg::*;

    logic [1:0] ofs;

    assign addr_o = op1_i + op2_i;
    assign ofs    = addr_o[1:0];

    always_comb begin
        cs_o    = 1'b0;
        we_o    = 1'b0;
        be_o    = '0;
        wdata_o = '0;
        if (inst_i[6:0] == op_load) begin
            cs_o = 1'b1;   // read, no lanes
        end else if (inst_i[6:0] == op_store) begin
            cs_o = 1'b1;
            case (inst_i[14:12])
                f3_sb: begin
                    we_o    = 1'b1;
                    be_o    = byte_lanes'(1) << ofs;
                    wdata_o = {{(xlen-8){1'b0}}, rs2_data_i[7:0]} << {ofs, 3'b000};
                end
                f3_sh: begin
                    we_o = 1'b1;
                    if (ofs == 2'b00) begin
                        be_o    = 4'b0011;
                        wdata_o = {16'h0, rs2_data_i[15:0]};
                    end else begin
                        be_o    = 4'b1100;   // upper half
                        wdata_o = {rs2_data_i[15:0], 16'h0};
                    end
                end
                f3_sw: begin
                    we_o    = 1'b1;
                    be_o    = '1;
                    wdata_o = rs2_data_i;
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        assert #0 (!we_o || be_o != '0) else $error("store without byte lanes");
    end

endmodule

//--- hw/ex_pkg.sv
// package with widths, opcodes, funct codes, divider state type and constants
package ex_pkg;

    // ------------------------------------------------------------
    // widths
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int byte_lanes = xlen / 8;
    localparam int div_iters  = xlen;       // one quotient bit per cycle
    localparam int count_w    = 6;

    // ------------------------------------------------------------
    // major opcodes
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;

    // alu funct3
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // branch funct3
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    // store funct3
    localparam logic [2:0] f3_sb = 3'b000;
    localparam logic [2:0] f3_sh = 3'b001;
    localparam logic [2:0] f3_sw = 3'b010;

    // divide funct3, only under f7_muldiv
    localparam logic [2:0] f3_div  = 3'b100;
    localparam logic [2:0] f3_divu = 3'b101;
    localparam logic [2:0] f3_rem  = 3'b110;
    localparam logic [2:0] f3_remu = 3'b111;

    // funct7
    localparam logic [6:0] f7_base   = 7'b0000000;
    localparam logic [6:0] f7_alt    = 7'b0100000;   // sub, sra
    localparam logic [6:0] f7_muldiv = 7'b0000001;

    localparam logic [xlen-1:0] reset_pc = '0;   // jump target when idle

    typedef enum logic [1:0] {
        div_idle,
        div_busy,
        div_done
    } div_state_t;

endpackage

//--- hw/ex_top.sv
// execute stage top: alu, branch, memory request, divider and writeback merge
`timescale 1ns/1ns
module ex_top (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          valid_i,
    input  logic [ex_pkg::xlen-1:0]       inst_i,
    input  logic [ex_pkg::xlen-1:0]       pc_i,
    input  logic [ex_pkg::xlen-1:0]       rs1_data_i,
    input  logic [ex_pkg::xlen-1:0]       rs2_data_i,
    input  logic [ex_pkg::xlen-1:0]       op1_i,
    input  logic [ex_pkg::xlen-1:0]       op2_i,
    output logic                          rd_wen_o,
    output logic [ex_pkg::reg_addr_w-1:0] rd_addr_o,
    output logic [ex_pkg::xlen-1:0]       rd_data_o,
    output logic                          jump_en_o,
    output logic [ex_pkg::xlen-1:0]       jump_addr_o,
    output logic                          hold_o,
    output logic                          mem_cs_o,
    output logic                          mem_we_o,
    output logic [ex_pkg::byte_lanes-1:0] mem_be_o,
    output logic [ex_pkg::xlen-1:0]       mem_addr_o,
    output logic [ex_pkg::xlen-1:0]       mem_wdata_o
);
    import ex_pkg::*;

    logic [xlen-1:0]       alu_result;
    logic                  alu_wen;
    logic                  br_jump;
    logic                  req_cs;
    logic                  req_we;
    logic [byte_lanes-1:0] req_be;
    logic                  is_div;
    logic                  div_start;
    logic                  div_busy;
    logic                  div_step;
    logic                  div_ready;
    logic                  div_last;
    logic [xlen-1:0]       div_result;
    logic [reg_addr_w-1:0] div_rd;
    logic [reg_addr_w-1:0] wb_rd;

    ex_alu i_ex_alu (
        .inst_i(inst_i), .op1_i(op1_i), .op2_i(op2_i),
        .result_o(alu_result), .wen_o(alu_wen)
    );

    ex_branch i_ex_branch (
        .inst_i(inst_i), .pc_i(pc_i), .rs1_data_i(rs1_data_i),
        .op1_i(op1_i), .op2_i(op2_i),
        .jump_en_o(br_jump), .jump_addr_o(jump_addr_o)
    );

    ex_mem_req i_ex_mem_req (
        .inst_i(inst_i), .op1_i(op1_i), .op2_i(op2_i), .rs2_data_i(rs2_data_i),
        .cs_o(req_cs), .we_o(req_we), .be_o(req_be),
        .addr_o(mem_addr_o), .wdata_o(mem_wdata_o)
    );

    // ------------------------------------------------------------
    // divide issue, only from idle
    always_comb begin
        is_div = 1'b0;
        if (inst_i[6:0] == op_reg && inst_i[31:25] == f7_muldiv) begin
            case (inst_i[14:12])
                f3_div, f3_divu, f3_rem, f3_remu: is_div = 1'b1;
                default:                          is_div = 1'b0;   // multiply dropped
            endcase
        end
    end
    assign div_start = valid_i && is_div && !div_busy;

    ex_div_ctrl i_ex_div_ctrl (
        .clk(clk), .rstn(rstn), .start_i(div_start), .last_i(div_last),
        .busy_o(div_busy), .step_o(div_step), .done_o(div_ready), .hold_o(hold_o)
    );

    ex_div_count i_ex_div_count (
        .clk(clk), .rstn(rstn), .load_i(div_start), .step_i(div_step), .last_o(div_last)
    );

    ex_div_datapath i_ex_div_datapath (
        .clk(clk), .rstn(rstn), .start_i(div_start), .step_i(div_step),
        .funct3_i(inst_i[14:12]), .dividend_i(rs1_data_i), .divisor_i(rs2_data_i),
        .rd_addr_i(inst_i[11:7]), .result_o(div_result), .rd_addr_o(div_rd)
    );

    // ------------------------------------------------------------
    // writeback merge, divide result wins in its done cycle
    assign wb_rd     = div_ready ? div_rd : inst_i[11:7];
    assign rd_addr_o = wb_rd;
    assign rd_data_o = div_ready ? div_result : alu_result;
    assign rd_wen_o  = (div_ready || (valid_i && alu_wen)) && wb_rd != '0;

    assign jump_en_o = valid_i && br_jump;
    assign mem_cs_o  = valid_i && req_cs;
    assign mem_we_o  = valid_i && req_we;
    assign mem_be_o  = valid_i ? req_be : '0;

    a_div_wb_no_hold: assert property (@(posedge clk) disable iff (!rstn)
        i_ex_div_ctrl.state_q == div_done && rd_wen_o |-> !hold_o);

endmodule

//--- src.f
+incdir+test
hw/ex_pkg.sv
hw/ex_alu.sv
hw/ex_branch.sv
hw/ex_mem_req.sv
hw/ex_div_ctrl.sv
hw/ex_div_count.sv
hw/ex_div_datapath.sv
hw/ex_top.sv
test/ex_tb.sv

//--- test/ex_tb_table.svh
// stimulus and expected value rows for the execute stage testbench
// columns: inst, pc, op1, op2, rs1, rs2, rd_wen, rd_data, jump_en, jump_addr,
//          mem_cs, mem_we, mem_be, mem_addr, mem_wdata, is_div
task automatic fill_table();
    // ------------------------------------------------------------
    // alu, destination x5
    add_row('h000002b3, 0, 5, 7, 0, 0, 1, 'hc, 0, 0, 0, 0, 0, 'hc, 0, 0);           // add
    add_row('h400002b3, 0, 5, 7, 0, 0, 1, 'hfffffffe, 0, 0, 0, 0, 0, 'hc, 0, 0);    // sub
    add_row('h000042b3, 0, 'hf0f, 'hff, 0, 0, 1, 'hff0, 0, 0, 0, 0, 0, 'h100e, 0, 0);
    add_row('h000062b3, 0, 'hf0f, 'hff, 0, 0, 1, 'hfff, 0, 0, 0, 0, 0, 'h100e, 0, 0);
    add_row('h000072b3, 0, 'hf0f, 'hff, 0, 0, 1, 'hf, 0, 0, 0, 0, 0, 'h100e, 0, 0);
    add_row('h000022b3, 0, 'h80000000, 1, 0, 0, 1, 1, 0, 0, 0, 0, 0, 'h80000001, 0, 0);
    add_row('h000032b3, 0, 'h80000000, 1, 0, 0, 1, 0, 0, 0, 0, 0, 0, 'h80000001, 0, 0);
    add_row('h00001293, 0, 1, 31, 0, 0, 1, 'h80000000, 0, 0, 0, 0, 0, 'h20, 0, 0);  // slli
    add_row('h000052b3, 0, 'h80000000, 31, 0, 0, 1, 1, 0, 0, 0, 0, 0, 'h8000001f, 0, 0);
    add_row('h400052b3, 0, 'h80000000, 31, 0, 0, 1, '1, 0, 0, 0, 0, 0, 'h8000001f, 0, 0);
    add_row('h00000013, 0, 3, 4, 0, 0, 0, 7, 0, 0, 0, 0, 0, 7, 0, 0);   // x0, no write
    add_row('h123452b7, 0, 0, 'h12345000, 0, 0, 1, 'h12345000, 0, 0, 0, 0, 0, 'h12345000, 0, 0);
    add_row('h00001297, 'h100, 'h100, 'h1000, 0, 0, 1, 'h1100, 0, 0, 0, 0, 0, 'h1100, 0, 0);

    // ------------------------------------------------------------
    // jumps and branches, each condition taken then not taken
    add_row('h020000ef, 'h200, 'h200, 4, 0, 0, 1, 'h204, 1, 'h220, 0, 0, 0, 'h204, 0, 0);
    add_row('h005000e7, 'h200, 'h200, 4, 'h1000, 0, 1, 'h204, 1, 'h1004, 0, 0, 0, 'h204, 0, 0);
    add_row('h00000463, 'h100, 3, 3, 0, 0, 0, 0, 1, 'h108, 0, 0, 0, 6, 0, 0);        // beq
    add_row('h00000463, 'h100, 3, 4, 0, 0, 0, 0, 0, 0, 0, 0, 0, 7, 0, 0);
    add_row('hfe0018e3, 'h100, 3, 4, 0, 0, 0, 0, 1, 'hf0, 0, 0, 0, 7, 0, 0);         // bne -16
    add_row('hfe0018e3, 'h100, 3, 3, 0, 0, 0, 0, 0, 0, 0, 0, 0, 6, 0, 0);
    add_row('h00004463, 'h100, '1, 1, 0, 0, 0, 0, 1, 'h108, 0, 0, 0, 0, 0, 0);       // blt
    add_row('h00004463, 'h100, 1, '1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    add_row('h00005463, 'h100, 1, '1, 0, 0, 0, 0, 1, 'h108, 0, 0, 0, 0, 0, 0);       // bge
    add_row('h00005463, 'h100, '1, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    add_row('h00006463, 'h100, 1, '1, 0, 0, 0, 0, 1, 'h108, 0, 0, 0, 0, 0, 0);       // bltu
    add_row('h00006463, 'h100, '1, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    add_row('h00007463, 'h100, '1, 1, 0, 0, 0, 0, 1, 'h108, 0, 0, 0, 0, 0, 0);       // bgeu
    add_row('h00007463, 'h100, 1, '1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);

    // ------------------------------------------------------------
    // loads and stores, rs2 = a1b2c3d4
    add_row('h00002283, 0, 'h1000, 4, 0, 0, 0, 0, 0, 0, 1, 0, 0, 'h1004, 0, 0);
    add_row('h00000023, 0, 'h1000, 0, 0, 'ha1b2c3d4, 0, 0, 0, 0, 1, 1, 1, 'h1000, 'hd4, 0);
    add_row('h00000023, 0, 'h1000, 1, 0, 'ha1b2c3d4, 0, 0, 0, 0, 1, 1, 2, 'h1001, 'hd400, 0);
    add_row('h00000023, 0, 'h1000, 2, 0, 'ha1b2c3d4, 0, 0, 0, 0, 1, 1, 4, 'h1002, 'hd40000, 0);
    add_row('h00000023, 0, 'h1000, 3, 0, 'ha1b2c3d4, 0, 0, 0, 0, 1, 1, 8, 'h1003, 'hd4000000, 0);
    add_row('h00001023, 0, 'h1000, 0, 0, 'ha1b2c3d4, 0, 0, 0, 0, 1, 1, 3, 'h1000, 'hc3d4, 0);
    add_row('h00001023, 0, 'h1000, 1, 0, 'ha1b2c3d4, 0, 0, 0, 0, 1, 1, 'hc, 'h1001, 'hc3d40000, 0);
    add_row('h00001023, 0, 'h1000, 2, 0, 'ha1b2c3d4, 0, 0, 0, 0, 1, 1, 'hc, 'h1002, 'hc3d40000, 0);
    add_row('h00002023, 0, 'h1000, 0, 0, 'ha1b2c3d4, 0, 0, 0, 0, 1, 1, 'hf, 'h1000, 'ha1b2c3d4, 0);

    // ------------------------------------------------------------
    // divides, result checked in the done cycle
    add_row('h020042b3, 0, 0, 0, 'hfffffff9, 2, 1, 'hfffffffd, 0, 0, 0, 0, 0, 0, 0, 1);
    add_row('h02005533, 0, 0, 0, 100, 7, 1, 14, 0, 0, 0, 0, 0, 0, 0, 1);   // divu into x10
    add_row('h020062b3, 0, 0, 0, 'hfffffff9, 2, 1, 'hffffffff, 0, 0, 0, 0, 0, 0, 0, 1);
    add_row('h020072b3, 0, 0, 0, 100, 7, 1, 2, 0, 0, 0, 0, 0, 0, 0, 1);
    add_row('h020042b3, 0, 0, 0, 'h1234, 0, 1, 'hffffffff, 0, 0, 0, 0, 0, 0, 0, 1);  // x/0
    add_row('h020062b3, 0, 0, 0, 'hfffffff9, 0, 1, 'hfffffff9, 0, 0, 0, 0, 0, 0, 0, 1);
    add_row('h020042b3, 0, 0, 0, 'h80000000, '1, 1, 'h80000000, 0, 0, 0, 0, 0, 0, 0, 1);
    add_row('h020062b3, 0, 0, 0, 'h80000000, '1, 1, 0, 0, 0, 0, 0, 0, 0, 0, 1);
endtask

//--- test/ex_tb.sv
// execute stage testbench: clock, reset, check task, table loop, random divides, timeout
`timescale 1ns/1ns
module ex_tb;
    import ex_pkg::*;

    localparam int reset_cycles = 8;
    localparam int cycle_budget = 40;   // per table row or divide
    localparam int n_random     = 50;
    localparam int div_latency  = 33;

    typedef struct packed {
        logic [31:0] inst;
        logic [31:0] pc;
        logic [31:0] op1;
        logic [31:0] op2;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic        wen;
        logic [31:0] data;
        logic        jen;
        logic [31:0] jaddr;
        logic        cs;
        logic        we;
        logic [3:0]  be;
        logic [31:0] maddr;
        logic [31:0] wdata;
        logic        is_div;
    } row_t;

    logic                  clk;
    logic                  rstn;
    logic                  valid_i;
    logic [xlen-1:0]       inst_i;
    logic [xlen-1:0]       pc_i;
    logic [xlen-1:0]       rs1_data_i;
    logic [xlen-1:0]       rs2_data_i;
    logic [xlen-1:0]       op1_i;
    logic [xlen-1:0]       op2_i;
    logic                  rd_wen_o;
    logic [reg_addr_w-1:0] rd_addr_o;
    logic [xlen-1:0]       rd_data_o;
    logic                  jump_en_o;
    logic [xlen-1:0]       jump_addr_o;
    logic                  hold_o;
    logic                  mem_cs_o;
    logic                  mem_we_o;
    logic [byte_lanes-1:0] mem_be_o;
    logic [xlen-1:0]       mem_addr_o;
    logic [xlen-1:0]       mem_wdata_o;

    row_t   rows[$];
    integer seed;
    int     cycle_count = 0;
    int     max_cycles;

    ex_top i_ex_top (
        .clk(clk), .rstn(rstn), .valid_i(valid_i), .inst_i(inst_i), .pc_i(pc_i),
        .rs1_data_i(rs1_data_i), .rs2_data_i(rs2_data_i), .op1_i(op1_i), .op2_i(op2_i),
        .rd_wen_o(rd_wen_o), .rd_addr_o(rd_addr_o), .rd_data_o(rd_data_o),
        .jump_en_o(jump_en_o), .jump_addr_o(jump_addr_o), .hold_o(hold_o),
        .mem_cs_o(mem_cs_o), .mem_we_o(mem_we_o), .mem_be_o(mem_be_o),
        .mem_addr_o(mem_addr_o), .mem_wdata_o(mem_wdata_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > max_cycles) begin
            $display("timeout: the run went past its limit of %0d cycles", max_cycles);
            $display("*** FAILED ***");
            $fatal(1, "stopped by the cycle limit");
        end
    end

    // ------------------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] act,
                               input logic [31:0] exp);
        if (act !== exp) begin
            $display("ERR %0t %s actual %h expected %h", $time, name, act, exp);
            $display("*** FAILED ***");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic add_row(input logic [31:0] inst, input logic [31:0] pc,
                           input logic [31:0] op1, input logic [31:0] op2,
                           input logic [31:0] rs1, input logic [31:0] rs2,
                           input logic wen, input logic [31:0] data,
                           input logic jen, input logic [31:0] jaddr,
                           input logic cs, input logic we, input logic [3:0] be,
                           input logic [31:0] maddr, input logic [31:0] wdata,
                           input logic is_div);
        rows.push_back({inst, pc, op1, op2, rs1, rs2, wen, data, jen, jaddr,
                        cs, we, be, maddr, wdata, is_div});
    endtask

    `include "ex_tb_table.svh"

    // RISC-V divide rules, including x/0 and min/-1
    function automatic logic [31:0] div_model(input logic [2:0] f3, input logic [31:0] a,
                                              input logic [31:0] b);
        logic signed [31:0] sq;
        logic signed [31:0] sr;
        logic               ovf;
        logic [31:0]        res;
        sq  = $signed(a) / $signed(b);
        sr  = $signed(a) % $signed(b);
        ovf = a == 32'h80000000 && b == 32'hffffffff;
        case (f3)
            f3_div:  res = (b == '0) ? '1 : (ovf ? a : sq);
            f3_rem:  res = (b == '0) ? a : (ovf ? '0 : sr);
            f3_divu: res = (b == '0) ? '1 : a / b;
            default: res = (b == '0) ? a : a % b;
        endcase
        return res;
    endfunction

    task automatic wait_div(input logic [31:0] exp_data, input logic [4:0] exp_rd);
        int lat;
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
            if (!rd_wen_o) begin
                check_value("hold_o", hold_o, 1'b1);   // stall until the result
            end
        end while (!rd_wen_o);
        check_value("divide latency", lat, div_latency);
        check_value("hold_o", hold_o, 1'b0);
        check_value("rd_data_o", rd_data_o, exp_data);
        check_value("rd_addr_o", rd_addr_o, exp_rd);
    endtask

    task automatic apply_row(input row_t r);
        @(negedge clk);
        valid_i    = 1'b1;
        inst_i     = r.inst;
        pc_i       = r.pc;
        op1_i      = r.op1;
        op2_i      = r.op2;
        rs1_data_i = r.rs1;
        rs2_data_i = r.rs2;
        #10;
        check_value("jump_en_o", jump_en_o, r.jen);
        check_value("jump_addr_o", jump_addr_o, r.jaddr);
        check_value("mem_cs_o", mem_cs_o, r.cs);
        check_value("mem_we_o", mem_we_o, r.we);
        check_value("mem_be_o", mem_be_o, r.be);
        check_value("mem_addr_o", mem_addr_o, r.maddr);
        check_value("mem_wdata_o", mem_wdata_o, r.wdata);
        if (r.is_div) begin
            check_value("hold_o", hold_o, 1'b1);   // issue cycle
            check_value("rd_wen_o", rd_wen_o, 1'b0);
            wait_div(r.data, r.inst[11:7]);
        end else begin
            check_value("hold_o", hold_o, 1'b0);
            check_value("rd_wen_o", rd_wen_o, r.wen);
            check_value("rd_data_o", rd_data_o, r.data);
            if (r.wen) begin
                check_value("rd_addr_o", rd_addr_o, r.inst[11:7]);
            end
        end
    endtask

    task automatic random_divide();
        logic [31:0] a;
        logic [31:0] b;
        logic [2:0]  f3;
        logic [4:0]  rd;
        int          sel;
        row_t        r;
        a   = $random(seed);
        b   = $random(seed);
        f3  = 3'b100 | ($random(seed) & 3);
        rd  = $random(seed) | 1;   // never x0
        sel = $random(seed) & 7;
        if (sel == 0) begin
            b = '0;
        end else if (sel == 1) begin
            a = 32'h80000000;
            b = 32'hffffffff;
        end else if (sel == 2) begin
            b = b & 32'hff;   // small divisor
        end
        r = {{f7_muldiv, 10'b0, f3, rd, op_reg}, 32'h0, 32'h0, 32'h0, a, b,
             1'b1, div_model(f3, a, b), 1'b0, 32'h0, 1'b0, 1'b0, 4'h0, 32'h0, 32'h0, 1'b1};
        apply_row(r);
    endtask

    // ------------------------------------------------------------
    initial begin
        seed       = 32'hd10e3b87;
        rstn       = 1'b0;
        valid_i    = 1'b0;
        inst_i     = '0;
        pc_i       = '0;
        op1_i      = '0;
        op2_i      = '0;
        rs1_data_i = '0;
        rs2_data_i = '0;
        fill_table();
        max_cycles = reset_cycles + cycle_budget * (rows.size() + n_random);
        repeat (reset_cycles) @(negedge clk);
        rstn = 1'b1;
        #10;
        check_value("rd_wen_o", rd_wen_o, 1'b0);
        check_value("jump_en_o", jump_en_o, 1'b0);
        check_value("hold_o", hold_o, 1'b0);
        check_value("mem_cs_o", mem_cs_o, 1'b0);
        check_value("mem_we_o", mem_we_o, 1'b0);
        foreach (rows[i]) begin
            apply_row(rows[i]);
        end
        for (int i = 0; i < n_random; i++) begin
            random_divide();   // back to back
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule
